// ==== list.f ====
hdl/posit_pkg.sv
hdl/posit_decode.sv
hdl/core_add_sub.sv
hdl/core_mul.sv
hdl/core_div.sv
hdl/core_op.sv
hdl/posit_encode.sv
hdl/posit_unit.sv
verification/posit_unit_sva.sv
verification/posit_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module posit_unit_tb -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -q "^TEST PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verification/posit_unit_tb.sv ====
/*
 * Testbench for the posit arithmetic unit.
 * Directed posit<16,1> cases, random identities and a back-to-back pipeline check.
 */
`timescale 1ns/1ps

module posit_unit_tb;

    localparam int NUM_RAND    = 20;
    localparam int NUM_OPS     = 20 + 8 * NUM_RAND;
    localparam int OP_CYCLES   = 3;
    localparam int WATCHDOG_NS = (NUM_OPS * OP_CYCLES + 20) * 10;

    localparam logic [15:0] NAR    = 16'h8000;
    localparam logic [15:0] ONE    = 16'h4000;
    localparam logic [15:0] MAXPOS = 16'h7FFF;
    localparam logic [15:0] MINPOS = 16'h0001;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           in_valid;
    posit_pkg::op_t op;
    logic [15:0]    a;
    logic [15:0]    b;
    logic           out_valid;
    logic [15:0]    result;

    integer seed = 51;
    integer err_count = 0;
    integer check_count = 0;

    posit_unit #(.N(16), .ES(1)) dut_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .op(op),
        .a(a), .b(b), .out_valid(out_valid), .result(result)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] neg_posit(input logic [15:0] x);
        return ~x + 16'd1; // Posit negation is two's complement.
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR result (%s): got 0x%04h, expected 0x%04h", name, got, exp);
        end
    endtask

    // One strobe, then the result two cycles later.
    task automatic run_op(input posit_pkg::op_t o, input logic [15:0] x,
                          input logic [15:0] y, output logic [15:0] res);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = y;
        @(posedge clk);
        #1 in_valid = 1'b0;
        @(posedge clk);
        #1;
        if (!out_valid) begin
            err_count++;
            $display("out_valid did not rise two cycles after the strobe at %0t", $time);
        end
        res = result;
    endtask

    task automatic random_posit(output logic [15:0] x);
        x = 16'($random(seed));
        while (x == 16'h0000 || x == NAR) begin
            x = 16'($random(seed));
        end
    endtask

    task automatic exact_arith();
        logic [15:0] r;
        run_op(posit_pkg::ADD, ONE, ONE, r);
        check_word("1 + 1", r, 16'h5000);
        run_op(posit_pkg::SUB, 16'h5800, ONE, r);
        check_word("3 - 1", r, 16'h5000);
        run_op(posit_pkg::MUL, 16'h4800, 16'h5000, r);
        check_word("1.5 * 2", r, 16'h5800);
        run_op(posit_pkg::DIV, 16'h5800, 16'h5000, r);
        check_word("3 / 2", r, 16'h4800);
        run_op(posit_pkg::MUL, 16'h2000, 16'h6000, r);
        check_word("0.25 * 4", r, ONE);
    endtask

    task automatic rounding_cases();
        logic [15:0] r;
        // 0x00C0 is 2^-13, half an ulp of 1.0.
        run_op(posit_pkg::ADD, ONE, 16'h00C0, r);
        check_word("tie to even, down", r, ONE);
        run_op(posit_pkg::ADD, 16'h4001, 16'h00C0, r);
        check_word("tie to even, up", r, 16'h4002);
        run_op(posit_pkg::MUL, MAXPOS, MAXPOS, r);
        check_word("maxpos * maxpos", r, MAXPOS);
        run_op(posit_pkg::MUL, MINPOS, MINPOS, r);
        check_word("minpos * minpos", r, MINPOS);
    endtask

    task automatic random_identities();
        logic [15:0] x;
        logic [15:0] r;
        for (int i = 0; i < NUM_RAND; i++) begin
            random_posit(x);
            run_op(posit_pkg::SUB, x, x, r);
            check_word("x - x", r, 16'h0000);
            run_op(posit_pkg::MUL, x, ONE, r);
            check_word("x * 1", r, x);
            run_op(posit_pkg::DIV, x, ONE, r);
            check_word("x / 1", r, x);
            run_op(posit_pkg::DIV, x, x, r);
            check_word("x / x", r, ONE);
        end
    endtask

    task automatic sign_symmetry();
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] p;
        logic [15:0] q;
        for (int i = 0; i < NUM_RAND; i++) begin
            random_posit(x);
            random_posit(y);
            run_op(posit_pkg::MUL, x, y, p);
            run_op(posit_pkg::MUL, neg_posit(x), y, q);
            check_word("(-x) * y", q, neg_posit(p));
            run_op(posit_pkg::SUB, x, y, p);
            run_op(posit_pkg::ADD, x, neg_posit(y), q);
            check_word("x + (-y)", q, p);
        end
    endtask

    task automatic special_values();
        logic [15:0] r;
        run_op(posit_pkg::ADD, NAR, ONE, r);
        check_word("NaR + 1", r, NAR);
        run_op(posit_pkg::SUB, 16'h5800, NAR, r);
        check_word("3 - NaR", r, NAR);
        run_op(posit_pkg::MUL, NAR, 16'h0000, r);
        check_word("NaR * 0", r, NAR);
        run_op(posit_pkg::DIV, ONE, NAR, r);
        check_word("1 / NaR", r, NAR);
        run_op(posit_pkg::DIV, 16'h5800, 16'h0000, r);
        check_word("3 / 0", r, NAR);
        run_op(posit_pkg::MUL, 16'h0000, 16'h5800, r);
        check_word("0 * 3", r, 16'h0000);
        run_op(posit_pkg::ADD, 16'h0000, 16'hB800, r);
        check_word("0 + -1.5", r, 16'hB800);
    endtask

    task automatic back_to_back();
        posit_pkg::op_t ops [4];
        logic [15:0]    xs [4];
        logic [15:0]    ys [4];
        logic [15:0]    want [4];
        ops = '{posit_pkg::ADD, posit_pkg::MUL, posit_pkg::DIV, posit_pkg::SUB};
        xs  = '{ONE, 16'h4800, 16'h5800, 16'h5000};
        ys  = '{ONE, 16'h5000, 16'h5000, ONE};
        want = '{16'h5000, 16'h5800, 16'h4800, ONE};
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #1;
            if (i >= 2) begin
                if (!out_valid) begin
                    err_count++;
                    $display("out_valid low for pipelined operation %0d", i - 2);
                end
                check_word("pipelined", result, want[i-2]);
            end
            in_valid = (i < 4);
            if (i < 4) begin
                op = ops[i];
                a  = xs[i];
                b  = ys[i];
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = posit_pkg::ADD;
        a        = 16'h0000;
        b        = 16'h0000;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        exact_arith();
        rounding_cases();
        random_identities();
        sign_symmetry();
        special_values();
        back_to_back();
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog, sized from the number of operations.
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verification/posit_unit_sva.sv ====
/*
 * Assertions for the posit arithmetic unit.
 * Strobe latency, reset state and a known result while out_valid is high.
 */
`timescale 1ns/1ps

module posit_unit_sva #(
    parameter int N = 16
) (
    input logic         clk,
    input logic         rst_n,
    input logic         in_valid,
    input logic         out_valid,
    input logic [N-1:0] result
);

    logic [1:0] ticks; // Clock edges seen, saturating.

    initial ticks = 2'd0;

    always @(posedge clk) begin
        if (ticks != 2'd3) begin
            ticks <= ticks + 2'd1;
        end
    end

    assert property (@(posedge clk)
        (ticks >= 2'd2 && $past(rst_n) && $past(rst_n, 2)) |-> out_valid == $past(in_valid, 2))
        else $error("out_valid is not in_valid delayed by two cycles");

    assert property (@(posedge clk) (ticks >= 2'd1 && !$past(rst_n)) |-> !out_valid)
        else $error("out_valid high in the cycle after reset");

    assert property (@(posedge clk) out_valid |-> !$isunknown(result))
        else $error("result unknown while out_valid is high");

endmodule

bind posit_unit posit_unit_sva #(.N(N)) sva_i (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid), .result(result)
);

// ==== hdl/posit_unit.sv ====
/*
 * Pipelined posit arithmetic unit.
 * Decode, register, compute and encode with special-case override. Two-cycle latency.
 */
`timescale 1ns/1ps

module posit_unit #(
    parameter int  N  = 16,
    parameter int  ES = 1,
    localparam int TE = posit_pkg::te_size(N, ES),
    localparam int M  = posit_pkg::mant_size(N, ES),
    localparam int F  = posit_pkg::frac_full_size(N, ES)
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  posit_pkg::op_t op,
    input  logic [N-1:0]   a,
    input  logic [N-1:0]   b,
    output logic           out_valid,
    output logic [N-1:0]   result
);

    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

    logic [N-1:0]         opnd [2];
    logic                 d_sign [2];
    logic signed [TE-1:0] d_te [2];
    logic [M-1:0]         d_mant [2];
    logic                 d_zero [2];
    logic                 d_nar [2];

    logic                 valid_q;
    posit_pkg::op_t       op_q;
    logic [N-1:0]         opnd_q [2];
    logic                 sign_q [2];
    logic signed [TE-1:0] te_q [2];
    logic [M-1:0]         mant_q [2];
    logic                 zero_q [2];
    logic                 nar_q [2];

    logic signed [TE-1:0] te_core;
    logic [F-1:0]         frac_core;
    logic                 trunc_core;
    logic                 sign_add_sub;
    logic                 is_add_sub;
    logic                 res_sign;
    logic                 cancel;
    logic [N-1:0]         enc_word;
    logic [N-1:0]         final_word;

    assign opnd[0] = a;
    assign opnd[1] = b;

    for (genvar g = 0; g < 2; g++) begin : g_dec
        posit_decode #(.N(N), .ES(ES)) dec_i (
            .word(opnd[g]), .sign(d_sign[g]), .te(d_te[g]), .mant(d_mant[g]),
            .is_zero(d_zero[g]), .is_nar(d_nar[g])
        );
    end

    // Stage 1, decoded operands.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q <= op;
            for (int i = 0; i < 2; i++) begin
                opnd_q[i] <= opnd[i];
                sign_q[i] <= d_sign[i];
                te_q[i]   <= d_te[i];
                mant_q[i] <= d_mant[i];
                zero_q[i] <= d_zero[i];
                nar_q[i]  <= d_nar[i];
            end
        end
    end

    core_op #(.N(N), .ES(ES)) core_op_i (
        .op(op_q), .sign1(sign_q[0]), .sign2(sign_q[1]),
        .te1(te_q[0]), .te2(te_q[1]), .mant1(mant_q[0]), .mant2(mant_q[1]),
        .te_out_core_op(te_core), .frac_out_core_op(frac_core),
        .frac_truncated(trunc_core), .sign_out(sign_add_sub)
    );

    assign is_add_sub = (op_q == posit_pkg::ADD) || (op_q == posit_pkg::SUB);
    assign res_sign   = is_add_sub ? sign_add_sub : sign_q[0] ^ sign_q[1];

    // Equal magnitudes with opposite effective signs cancel exactly.
    assign cancel = is_add_sub && te_q[0] == te_q[1] && mant_q[0] == mant_q[1]
                    && (sign_q[0] ^ sign_q[1] ^ (op_q == posit_pkg::SUB));

    posit_encode #(.N(N), .ES(ES)) enc_i (
        .sign(res_sign), .te(te_core), .frac(frac_core),
        .frac_truncated(trunc_core), .word(enc_word)
    );

    always_comb begin
        final_word = enc_word;
        if (nar_q[0] || nar_q[1] || (op_q == posit_pkg::DIV && zero_q[1])) begin
            final_word = NAR;
        end else if (op_q == posit_pkg::MUL && (zero_q[0] || zero_q[1])) begin
            final_word = '0;
        end else if (op_q == posit_pkg::DIV && zero_q[0]) begin
            final_word = '0;
        end else if (zero_q[1]) begin
            final_word = opnd_q[0]; // a + 0 and a - 0.
        end else if (zero_q[0]) begin
            final_word = (op_q == posit_pkg::SUB) ? -opnd_q[1] : opnd_q[1];
        end else if (cancel) begin
            final_word = '0;
        end
    end

    // Stage 2, result register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= valid_q;
            if (valid_q) begin
                result <= final_word;
            end
        end
    end

endmodule

// ==== hdl/posit_encode.sv ====
/*
 * Posit encoder.
 * Builds regime, exponent and fraction from te, rounds to nearest even.
 */
`timescale 1ns/1ps

module posit_encode #(
    parameter int  N  = 16,
    parameter int  ES = 1,
    localparam int TE = posit_pkg::te_size(N, ES),
    localparam int F  = posit_pkg::frac_full_size(N, ES),
    localparam int W  = 2 + ES + F + N
) (
    input  logic                 sign,
    input  logic signed [TE-1:0] te,
    input  logic [F-1:0]         frac,
    input  logic                 frac_truncated,
    output logic [N-1:0]         word
);

    logic signed [TE-1:0] k;
    logic [TE-1:0]        shamt;
    logic [W-1:0]         seed;
    logic [W-1:0]         body;
    logic [N-2:0]         trunc_mag;
    logic                 guard;
    logic                 sticky;
    logic                 round_up;
    logic [N-1:0]         rounded;
    logic [N-2:0]         mag;

    assign k = te >>> ES; // Regime value, floor division.

    // Shift the terminator right, filling with the regime run.
    assign shamt = k[TE-1] ? ~k : k;
    assign seed  = {~k[TE-1], k[TE-1], te[ES-1:0], frac, {N{1'b0}}};

    always_comb begin
        if (k[TE-1]) begin
            body = seed >> shamt;
        end else begin
            body = $signed(seed) >>> shamt;
        end
    end

    assign trunc_mag = body[W-1 -: N-1];
    assign guard     = body[W-N];
    assign sticky    = |body[W-N-1:0] | frac_truncated;
    assign round_up  = guard & (sticky | trunc_mag[0]); // Ties go to even.
    assign rounded   = {1'b0, trunc_mag} + N'(round_up);

    // Never round into zero or NaR.
    always_comb begin
        if (k > N - 2 || rounded[N-1]) begin
            mag = {(N-1){1'b1}};
        end else if (k < 2 - N) begin
            mag = {{(N-2){1'b0}}, 1'b1};
        end else begin
            mag = rounded[N-2:0];
        end
    end

    assign word = sign ? -{1'b0, mag} : {1'b0, mag};

endmodule

// ==== hdl/core_op.sv ====
/*
 * Arithmetic core selector.
 * Runs add/sub, mul and div side by side and picks the result for op.
 */
`timescale 1ns/1ps

module core_op #(
    parameter int  N  = 16,
    parameter int  ES = 1,
    localparam int TE = posit_pkg::te_size(N, ES),
    localparam int M  = posit_pkg::mant_size(N, ES),
    localparam int F  = posit_pkg::frac_full_size(N, ES)
) (
    input  posit_pkg::op_t       op,
    input  logic                 sign1,
    input  logic                 sign2,
    input  logic signed [TE-1:0] te1,
    input  logic signed [TE-1:0] te2,
    input  logic [M-1:0]         mant1,
    input  logic [M-1:0]         mant2,
    output logic signed [TE-1:0] te_out_core_op,
    output logic [F-1:0]         frac_out_core_op,
    output logic                 frac_truncated,
    output logic                 sign_out
);

    logic [2*M-1:0]       mant_add_sub;
    logic [2*M-1:0]       mant_mul;
    logic [F-1:0]         mant_div;
    logic signed [TE-1:0] te_add_sub;
    logic signed [TE-1:0] te_mul;
    logic signed [TE-1:0] te_div;
    logic                 trunc_add_sub;
    logic                 trunc_mul;
    logic                 trunc_div;
    logic [F-1:0]         frac_add_sub;
    logic [F-1:0]         frac_mul;

    core_add_sub #(.N(N), .ES(ES)) add_sub_i (
        .te1(te1), .te2(te2), .mant1(mant1), .mant2(mant2),
        .sign1(sign1), .sign2(sign2), .sub(op == posit_pkg::SUB),
        .mant_out(mant_add_sub), .te_out(te_add_sub),
        .sign_out(sign_out), .frac_truncated(trunc_add_sub)
    );

    core_mul #(.N(N), .ES(ES)) mul_i (
        .te1(te1), .te2(te2), .mant1(mant1), .mant2(mant2),
        .mant_out(mant_mul), .te_out(te_mul), .frac_truncated(trunc_mul)
    );

    core_div #(.N(N), .ES(ES)) div_i (
        .te1(te1), .te2(te2), .mant1(mant1), .mant2(mant2),
        .mant_out(mant_div), .te_out(te_div), .frac_truncated(trunc_div)
    );

    // Left-align, then shift out the carry and hidden bits.
    assign frac_add_sub = (F'(mant_add_sub) << (F - 2 * M)) << 2;
    assign frac_mul     = (F'(mant_mul) << (F - 2 * M)) << 2;

    always_comb begin
        case (op)
            posit_pkg::MUL: begin
                te_out_core_op   = te_mul;
                frac_out_core_op = frac_mul;
                frac_truncated   = trunc_mul;
            end
            posit_pkg::DIV: begin
                te_out_core_op   = te_div;
                frac_out_core_op = mant_div; // Already fraction only.
                frac_truncated   = trunc_div;
            end
            default: begin
                te_out_core_op   = te_add_sub;
                frac_out_core_op = frac_add_sub;
                frac_truncated   = trunc_add_sub;
            end
        endcase
    end

endmodule

// ==== hdl/core_div.sv ====
/*
 * Mantissa divider.
 * Unrolled restoring division with exponent subtraction and normalization.
 */
`timescale 1ns/1ps

module core_div #(
    parameter int  N  = 16,
    parameter int  ES = 1,
    localparam int TE = posit_pkg::te_size(N, ES),
    localparam int M  = posit_pkg::mant_size(N, ES),
    localparam int F  = posit_pkg::frac_full_size(N, ES),
    localparam int Q  = F + 2
) (
    input  logic signed [TE-1:0] te1,
    input  logic signed [TE-1:0] te2,
    input  logic [M-1:0]         mant1,
    input  logic [M-1:0]         mant2,
    output logic [F-1:0]         mant_out,
    output logic signed [TE-1:0] te_out,
    output logic                 frac_truncated
);

    logic [Q-1:0] quot; // One integer bit, Q-1 fraction bits.
    logic [M:0]   rem;

    always_comb begin
        rem = {1'b0, mant1};
        for (int i = Q - 1; i >= 0; i--) begin
            if (rem >= {1'b0, mant2}) begin
                quot[i] = 1'b1;
                rem     = rem - {1'b0, mant2};
            end else begin
                quot[i] = 1'b0;
            end
            rem = rem << 1;
        end
    end

    // Quotient below one needs one more left shift.
    assign mant_out = quot[Q-1] ? quot[Q-2:1] : quot[Q-3:0];
    assign te_out   = te1 - te2 - TE'(!quot[Q-1]);

    assign frac_truncated = (rem != '0) | (quot[Q-1] & quot[0]);

endmodule

// ==== hdl/core_mul.sv ====
/*
 * Mantissa multiplier.
 * Forms the full product, adds exponents and normalizes into [1, 2).
 */
`timescale 1ns/1ps

module core_mul #(
    parameter int  N  = 16,
    parameter int  ES = 1,
    localparam int TE = posit_pkg::te_size(N, ES),
    localparam int M  = posit_pkg::mant_size(N, ES)
) (
    input  logic signed [TE-1:0] te1,
    input  logic signed [TE-1:0] te2,
    input  logic [M-1:0]         mant1,
    input  logic [M-1:0]         mant2,
    output logic [2*M-1:0]       mant_out,
    output logic signed [TE-1:0] te_out,
    output logic                 frac_truncated
);

    logic [2*M-1:0] product;
    logic           ovf;

    assign product = mant1 * mant2;
    assign ovf     = product[2*M-1]; // Product is two or more.

    // Leading one ends up one below the top bit.
    assign mant_out       = ovf ? product >> 1 : product;
    assign te_out         = te1 + te2 + TE'(ovf);
    assign frac_truncated = ovf & product[0];

endmodule

// ==== hdl/core_add_sub.sv ====
/*
 * Mantissa adder and subtractor.
 * Aligns, adds or subtracts, then normalizes with a leading-zero count.
 */
`timescale 1ns/1ps

module core_add_sub #(
    parameter int  N   = 16,
    parameter int  ES  = 1,
    localparam int TE  = posit_pkg::te_size(N, ES),
    localparam int M   = posit_pkg::mant_size(N, ES),
    localparam int R   = 2 * M,
    localparam int LZW = $clog2(R + 1)
) (
    input  logic signed [TE-1:0] te1,
    input  logic signed [TE-1:0] te2,
    input  logic [M-1:0]         mant1,
    input  logic [M-1:0]         mant2,
    input  logic                 sign1,
    input  logic                 sign2,
    input  logic                 sub,
    output logic [R-1:0]         mant_out,
    output logic signed [TE-1:0] te_out,
    output logic                 sign_out,
    output logic                 frac_truncated
);

    logic                 sign2_eff;
    logic                 swap;
    logic                 eff_sub;
    logic signed [TE-1:0] te_big;
    logic [TE-1:0]        te_diff;
    logic [TE-1:0]        shamt;
    logic [R-1:0]         big_ext;
    logic [R-1:0]         small_ext;
    logic [2*R-1:0]       small_full;
    logic [R-1:0]         small_sh;
    logic                 sticky;
    logic [R-1:0]         sum;
    logic [LZW-1:0]       lz;

    assign sign2_eff = sign2 ^ sub;
    assign eff_sub   = sign1 ^ sign2_eff;
    assign swap      = (te2 > te1) || (te2 == te1 && mant2 > mant1); // Larger magnitude first.

    assign te_big    = swap ? te2 : te1;
    assign te_diff   = swap ? te2 - te1 : te1 - te2;
    assign shamt     = (te_diff > TE'(R)) ? TE'(R) : te_diff;
    assign sign_out  = swap ? sign2_eff : sign1;

    // Carry bit, hidden bit, then fraction and guard bits.
    assign big_ext   = {1'b0, swap ? mant2 : mant1, {(M-1){1'b0}}};
    assign small_ext = {1'b0, swap ? mant1 : mant2, {(M-1){1'b0}}};

    assign small_full = {small_ext, {R{1'b0}}} >> shamt;
    assign small_sh   = small_full[2*R-1:R];
    assign sticky     = |small_full[R-1:0]; // Bits lost off the right.

    // A lost tail lowers the difference by less than one LSB.
    assign sum = eff_sub ? big_ext - small_sh - R'(sticky) : big_ext + small_sh;

    always_comb begin
        lz = LZW'(R);
        for (int i = 0; i < R; i++) begin
            if (sum[i]) begin
                lz = LZW'(R - 1 - i);
            end
        end
    end

    always_comb begin
        if (sum[R-1]) begin // Carry out, shift right.
            mant_out       = sum >> 1;
            te_out         = te_big + TE'(1);
            frac_truncated = sticky | sum[0];
        end else begin
            mant_out       = sum << (lz - 1'b1);
            te_out         = te_big - TE'(lz) + TE'(1);
            frac_truncated = sticky;
        end
    end

endmodule

// ==== hdl/posit_decode.sv ====
/*
 * Posit decoder.
 * Splits one posit word into sign, total exponent and mantissa with hidden bit.
 */
`timescale 1ns/1ps

module posit_decode #(
    parameter int  N  = 16,
    parameter int  ES = 1,
    localparam int TE = posit_pkg::te_size(N, ES),
    localparam int M  = posit_pkg::mant_size(N, ES)
) (
    input  logic [N-1:0]         word,
    output logic                 sign,
    output logic signed [TE-1:0] te,
    output logic [M-1:0]         mant,
    output logic                 is_zero,
    output logic                 is_nar
);

    logic [N-1:0]        neg_word;
    logic [N-2:0]        body;
    logic [N-2:0]        rest;
    logic [$clog2(N):0]  run;
    logic                run_done;
    logic signed [TE-1:0] regime;
    logic [ES-1:0]       exp_bits;

    assign is_zero  = (word == '0);
    assign is_nar   = (word == {1'b1, {(N-1){1'b0}}});
    assign sign     = word[N-1];
    assign neg_word = -word;
    assign body     = sign ? neg_word[N-2:0] : word[N-2:0]; // Magnitude without sign.

    // Length of the regime run.
    always_comb begin
        run      = '0;
        run_done = 1'b0;
        for (int i = N - 2; i >= 0; i--) begin
            if (!run_done && body[i] == body[N-2]) begin
                run = run + 1'b1;
            end else begin
                run_done = 1'b1;
            end
        end
    end

    // Ones give run - 1, zeros give -run.
    assign regime = body[N-2] ? TE'(run) - TE'(1) : -TE'(run);

    assign rest     = body << (run + 1'b1); // Drop regime and terminator.
    assign exp_bits = rest[N-2 -: ES];
    assign te       = (regime <<< ES) + $signed(TE'(exp_bits));
    assign mant     = {1'b1, rest[N-2-ES -: M-1]};

endmodule

// ==== hdl/posit_pkg.sv ====
/*
 * Posit datapath package.
 * Operation codes and the width helpers shared by the posit arithmetic unit.
 */
package posit_pkg;

    localparam int OP_SIZE = 2;

    typedef enum logic [OP_SIZE-1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        MUL = 2'd2,
        DIV = 2'd3
    } op_t;

    // Signed total exponent, regime * 2^es + exponent, with headroom for mul and div.
    function automatic int te_size(input int n, input int es);
        return $clog2(n) + es + 3;
    endfunction

    // Hidden bit plus the longest fraction field.
    function automatic int mant_size(input int n, input int es);
        return n - es - 2;
    endfunction

    // Fraction width at the core_op output.
    function automatic int frac_full_size(input int n, input int es);
        return 2 * mant_size(n, es);
    endfunction

endpackage
